//--- hw/calc_pkg.sv
`default_nettype none

package calc_pkg;

    // default build values, the top level can override them
    localparam int DEFAULT_DEBOUNCE = 10;   // stable synced cycles before a press counts
    localparam int DEFAULT_VALUE_W  = 16;   // arithmetic width, wraps modulo 2**w

    // operator codes
    // negate and clear act right away, the rest wait as the pending op
    typedef enum logic [2:0] {
        op_none   = 3'd0,   // nothing pending
        op_negate = 3'd1,   // sign change on the entry
        op_add    = 3'd2,
        op_sub    = 3'd3,
        op_mul    = 3'd4,
        op_clear  = 3'd5    // wipe everything
    } op_t;

    // what kind of key was pressed
    typedef enum logic [1:0] {
        kind_digit = 2'd0,  // 0..9, value in digit field
        kind_op    = 2'd1,  // operator, code in op field
        kind_equal = 2'd2   // equal sign
    } key_kind_t;

    // one key event, scanner to controller (9 bits)
    typedef struct packed {
        key_kind_t  kind;   // selects which field below is meaningful
        logic [3:0] digit;  // decimal digit for kind_digit
        op_t        op;     // operator for kind_op
    } key_event_t;

endpackage

`default_nettype wire

//--- hw/key_if.sv
`default_nettype none

// key event handshake
// valid stays up with a stable evt until ack has been seen high
interface key_if import calc_pkg::*; ();

    logic       valid;  // event waiting, from scanner
    logic       ack;    // one-cycle accept pulse, from controller
    key_event_t evt;    // decoded key, held while valid

    modport scanner (
        output valid,
        output evt,
        input  ack
    );

    modport controller (
        input  valid,
        input  evt,
        output ack
    );

endinterface

`default_nettype wire

//--- hw/keypad_scanner.sv
`default_nettype none

module keypad_scanner import calc_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE
) (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,   // rows, pulled up, low = pressed
    output logic [3:0] col_out,  // one column driven low at a time
    key_if.scanner     key
);

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    typedef enum logic [1:0] {
        st_scan,        // rotate columns, look for a low row
        st_debounce,    // column frozen, count stable low samples
        st_request,     // valid up, waiting for ack
        st_release      // wait for all rows high again
    } state_t;

    state_t     state;
    logic [1:0] col_idx;        // column currently driven
    logic [1:0] col_d1;         // column that row_s1 was sampled under
    logic [1:0] col_d2;         // column that row_s2 was sampled under
    logic [3:0] row_s1;         // first sync flop
    logic [3:0] row_s2;         // second sync flop, the only row value used
    logic [CNT_W-1:0] cnt;      // stable low samples so far

    logic       row_low;        // some synced row is low
    logic       sample_ok;      // synced rows belong to the driven column
    logic       stable_done;    // this sample completes the debounce
    logic [3:0] key_idx;        // row * 4 + column

    // lowest pressed row wins, others are ignored
    function automatic logic [1:0] low_row(input logic [3:0] rows);
        logic [1:0] r;
        r = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (!rows[i]) begin
                r = 2'(i);
            end
        end
        return r;
    endfunction

    // key index to event, same layout as the keypad face
    function automatic key_event_t key_map(input logic [3:0] idx);
        key_event_t e;
        e.kind  = kind_digit;
        e.digit = 4'd0;
        e.op    = op_none;
        case (idx)
            4'd0:  e.digit = 4'd1;
            4'd1:  e.digit = 4'd2;
            4'd2:  e.digit = 4'd3;
            4'd3:  begin e.kind = kind_op; e.op = op_add; end
            4'd4:  e.digit = 4'd4;
            4'd5:  e.digit = 4'd5;
            4'd6:  e.digit = 4'd6;
            4'd7:  begin e.kind = kind_op; e.op = op_sub; end
            4'd8:  e.digit = 4'd7;
            4'd9:  e.digit = 4'd8;
            4'd10: e.digit = 4'd9;
            4'd11: begin e.kind = kind_op; e.op = op_mul; end
            4'd12: e.kind = kind_equal;
            4'd13: e.digit = 4'd0;
            4'd14: begin e.kind = kind_op; e.op = op_clear; end
            default: begin e.kind = kind_op; e.op = op_negate; end  // 15
        endcase
        return e;
    endfunction

    // two-flop synchronizer on the rows, column index follows along
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_s1 <= 4'hf;
            row_s2 <= 4'hf;
            col_d1 <= 2'd0;
            col_d2 <= 2'd0;
        end else begin
            row_s1 <= row_in;
            row_s2 <= row_s1;
            col_d1 <= col_idx;   // tag each sample with its column
            col_d2 <= col_d1;
        end
    end

    assign row_low     = ~&row_s2;
    assign sample_ok   = (col_d2 == col_idx);
    assign stable_done = sample_ok && row_low && (int'(cnt) + 1 >= DEBOUNCE_CYCLES);
    assign key_idx     = {low_row(row_s2), col_idx};

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;   // active low column drive
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state     <= st_scan;
            col_idx   <= 2'd0;
            cnt       <= '0;
            key.valid <= 1'b0;
        end else begin
            case (state)
                st_scan: begin
                    if (row_low) begin
                        col_idx <= col_d2;        // back to the column that saw it
                        cnt     <= CNT_W'(1);     // detecting sample counts
                        state   <= st_debounce;
                    end else begin
                        col_idx <= col_idx + 2'd1;
                    end
                end
                st_debounce: begin
                    if (stable_done) begin
                        key.valid <= 1'b1;
                        state     <= st_request;
                    end else if (sample_ok && !row_low) begin
                        cnt   <= '0;              // bounce, start over
                        state <= st_scan;
                    end else if (sample_ok) begin
                        cnt <= cnt + 1'b1;
                    end
                end
                st_request: begin
                    if (key.ack) begin            // hold everything until accepted
                        key.valid <= 1'b0;
                        state     <= st_release;
                    end
                end
                default: begin                    // st_release
                    if (sample_ok && !row_low) begin
                        cnt     <= '0;
                        col_idx <= col_idx + 2'd1;
                        state   <= st_scan;
                    end
                end
            endcase
        end
    end

    // event payload, loaded once as valid rises
    always_ff @(posedge clk) begin
        if (state == st_debounce && stable_done) begin
            key.evt <= key_map(key_idx);
        end
    end

endmodule

`default_nettype wire

//--- hw/calc_controller.sv
`default_nettype none

module calc_controller import calc_pkg::*; #(
    parameter int VALUE_W = DEFAULT_VALUE_W
) (
    input  logic                      clk,
    input  logic                      nRST,
    key_if.controller                 key,
    output logic signed [VALUE_W-1:0] display   // running value shown
);

    localparam logic signed [VALUE_W-1:0] TEN = VALUE_W'(10);

    logic signed [VALUE_W-1:0] entry;        // operand being typed
    logic signed [VALUE_W-1:0] acc;          // left-hand side so far
    op_t                       pending;      // op waiting for its right operand

    logic                      take;         // event accepted this cycle
    logic signed [VALUE_W-1:0] digit_ext;    // digit widened to VALUE_W
    logic signed [VALUE_W-1:0] entry_shift;  // entry * 10 + digit
    logic signed [VALUE_W-1:0] entry_neg;    // -entry
    logic signed [VALUE_W-1:0] applied;      // pending op on acc and entry

    // all results wrap at VALUE_W bits
    function automatic logic signed [VALUE_W-1:0] apply_op(
        input op_t                       op,
        input logic signed [VALUE_W-1:0] a,
        input logic signed [VALUE_W-1:0] b
    );
        logic signed [VALUE_W-1:0] r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_mul:  r = a * b;    // low half of the product only
            default: r = b;        // nothing pending, operand passes through
        endcase
        return r;
    endfunction

    // one ack pulse per event, the cycle after valid is seen
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            key.ack <= 1'b0;
        end else begin
            key.ack <= key.valid && !key.ack;
        end
    end

    assign take        = key.valid && key.ack;   // evt still held here
    assign digit_ext   = $signed({{(VALUE_W-4){1'b0}}, key.evt.digit});
    assign entry_shift = entry * TEN + digit_ext;
    assign entry_neg   = -entry;
    assign applied     = apply_op(pending, acc, entry);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry   <= '0;
            acc     <= '0;
            pending <= op_none;
            display <= '0;
        end else if (take) begin
            case (key.evt.kind)
                kind_digit: begin
                    entry   <= entry_shift;  // append decimal digit
                    display <= entry_shift;
                end
                kind_op: begin
                    case (key.evt.op)
                        op_clear: begin
                            entry   <= '0;
                            acc     <= '0;
                            pending <= op_none;
                            display <= '0;
                        end
                        op_negate: begin
                            entry   <= entry_neg;   // acts on entry only
                            display <= entry_neg;
                        end
                        op_add, op_sub, op_mul: begin
                            acc     <= applied;     // chain left to right
                            pending <= key.evt.op;
                            entry   <= '0;
                            display <= applied;
                        end
                        default: ;
                    endcase
                end
                kind_equal: begin
                    // result also becomes the entry so a following op
                    // continues from it
                    acc     <= applied;
                    entry   <= applied;
                    pending <= op_none;
                    display <= applied;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/calc_top.sv
`default_nettype none

module calc_top import calc_pkg::*; #(
    parameter int DEBOUNCE_CYCLES = DEFAULT_DEBOUNCE,  // press must be stable this long
    parameter int VALUE_W         = DEFAULT_VALUE_W    // display and arithmetic width
) (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic [3:0]                row_in,    // keypad rows, active low
    output logic [3:0]                col_out,   // keypad columns, active low
    output logic signed [VALUE_W-1:0] display
);

    // event handshake between scanner and controller
    key_if key_bus ();

    // keypad side, rows in and columns out
    keypad_scanner #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) u_scan (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key     (key_bus.scanner)
    );

    // arithmetic side, drives the display
    calc_controller #(
        .VALUE_W (VALUE_W)
    ) u_ctrl (
        .clk     (clk),
        .nRST    (nRST),
        .key     (key_bus.controller),
        .display (display)
    );

endmodule

`default_nettype wire

//--- tb/calc_tb.sv
`default_nettype none

module calc_tb;

    timeunit 1ns;
    timeprecision 1ns;

    localparam int    DEBOUNCE_CYCLES = 10;
    localparam int    VALUE_W         = 16;
    localparam int    CLK_PERIOD      = 40;                 // ns
    localparam int    RESET_CYCLES    = 8;
    localparam int    LATENCY_BOUND   = 4 + 2 + DEBOUNCE_CYCLES + 2;  // press to valid
    localparam int    HOLD_CYCLES     = 3 * LATENCY_BOUND;  // key down time and key up time each
    localparam int    MAX_IDLE        = 5;                  // random gap between keys
    localparam int    KEY_CYCLES      = 2 * HOLD_CYCLES + MAX_IDLE + 2;
    localparam int    SEED            = 32'h14b1_2066;
    localparam string TRACE_FILE      = "tb/calc_trace.txt";

    logic                      clk = 1'b0;
    logic                      nRST;
    logic [3:0]                row_in;
    logic [3:0]                col_out;
    logic signed [VALUE_W-1:0] display;

    logic                      key_down;   // a switch is closed
    logic [3:0]                key_idx;    // pressed key as row * 4 + column

    logic [3:0]                trace_key[$];   // key per trace line
    logic signed [VALUE_W-1:0] trace_exp[$];   // display after that key
    logic                      trace_loaded;

    calc_top #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
        .VALUE_W         (VALUE_W)
    ) uut (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .display (display)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // a closed switch shorts its row to the driven column
    function automatic logic [3:0] row_level(
        input logic       down,
        input logic [3:0] idx,
        input logic [3:0] cols
    );
        logic [3:0] rows;
        rows = 4'hf;                 // pull-ups
        if (down && !cols[idx[1:0]]) begin
            rows[idx[3:2]] = 1'b0;   // only while its column is driven
        end
        return rows;
    endfunction

    // keypad model drives rows on the falling edge
    initial begin
        row_in = 4'hf;
        forever begin
            @(negedge clk);
            row_in = row_level(key_down, key_idx, col_out);
        end
    end

    task automatic check_display(input logic signed [VALUE_W-1:0] expected, input int step);
        if (display !== expected) begin
            $display("CHECK FAILED display: got %h expected %h (trace entry %0d)",
                     display, expected, step);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_cols(input logic [3:0] expected);
        if (col_out !== expected) begin
            $display("CHECK FAILED col_out: got %h expected %h", col_out, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // each line holds a key index and the display value after it
    // lines starting with # are comments
    task automatic load_trace();
        int          fd;
        int          n;
        int          idx;
        int          line_no;
        logic [31:0] exp_word;
        string       line;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("could not open the trace file %s", TRACE_FILE);
            $display("Test failed");
            $fatal(1);
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n == 0 || line.len() == 0) begin
                continue;                       // end of file
            end
            if (line.getc(0) == "#" || line.getc(0) == "\n" || line.getc(0) == "\r") begin
                continue;                       // comment or blank
            end
            n = $sscanf(line, "%d %h", idx, exp_word);
            if (n != 2 || idx < 0 || idx > 15) begin
                $display("trace line %0d is not a key index and a display value", line_no);
                $display("Test failed");
                $fatal(1);
            end
            trace_key.push_back(idx[3:0]);
            trace_exp.push_back(exp_word[VALUE_W-1:0]);
        end
        $fclose(fd);
        if (trace_key.size() == 0) begin
            $display("the trace file holds no key entries");
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // hold the key well past the debounce and release it as long
    task automatic press_key(input logic [3:0] idx);
        @(posedge clk);
        key_idx  = idx;
        key_down = 1'b1;
        repeat (HOLD_CYCLES) @(posedge clk);
        key_down = 1'b0;
        repeat (HOLD_CYCLES) @(posedge clk);   // event acked and display settled by now
    endtask

    // limit scales with the trace length
    initial begin : watchdog
        longint limit_ns;
        wait (trace_loaded);
        limit_ns = longint'(trace_key.size()) * 2 * KEY_CYCLES * CLK_PERIOD
                 + RESET_CYCLES * CLK_PERIOD;
        #(limit_ns);
        $display("watchdog: the run did not finish within %0d ns", limit_ns);
        $display("Test failed");
        $fatal(1);
    end

    initial begin
        nRST         = 1'b0;
        key_down     = 1'b0;
        key_idx      = 4'd0;
        trace_loaded = 1'b0;
        void'($urandom(SEED));           // one seed for the whole run

        load_trace();
        trace_loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        check_cols(4'b1110);             // column 0 selected out of reset
        check_display('0, 0);
        nRST = 1'b1;                     // release on a falling edge

        for (int i = 0; i < trace_key.size(); i++) begin
            press_key(trace_key[i]);
            @(negedge clk);              // display stable mid cycle
            check_display(trace_exp[i], i + 1);
            repeat ($urandom % (MAX_IDLE + 1)) @(posedge clk);
        end

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/calc_pkg.sv
hw/key_if.sv
hw/keypad_scanner.sv
hw/calc_controller.sv
hw/calc_top.sv
tb/calc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the calculator testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ns -j 0 \
    -f vlog.f --top-module calc_tb -o calc_sim > "$LOG" 2>&1 &&
    ./obj_dir/calc_sim >> "$LOG" 2>&1 ||
    echo "build or simulation stopped with an error" >> "$LOG"

cat "$LOG"

grep -q "Test failed" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -q "Test passed" "$LOG" || { echo "no pass result found in $LOG"; exit 1; }

echo "simulation passed, see $LOG"
exit 0

//--- tb/calc_trace.txt
# columns: key index (decimal, row * 4 + column), display after the key (hex, 16 bit)
# keys 0-2,4-6,8-10,13 digits, 3 add, 7 sub, 11 mul, 12 equal, 14 clear, 15 negate
# digit entry then chained add, sub, mul, equal
0 0001
1 000c
2 007b
3 007b
4 0004
5 002d
7 00a8
6 0006
11 00a2
8 0007
12 046e
14 0000
# negate, subtracting a negative number
5 0005
7 0005
2 0003
15 fffd
12 0008
14 0000
# entry wraps at 16 bits, multiply wraps too
10 0009
10 0063
10 03e7
10 270f
10 869f
11 869f
9 0008
12 34f8
# result carries into the next operation
3 34f8
13 0000
0 0001
12 34f9
# clear in the middle of an expression
14 0000
4 0004
3 0004
1 0002
14 0000
6 0006
12 0006
# result below zero
14 0000
1 0002
7 0002
8 0007
12 fffb
